/* logic/elink_macros.svh */
// Queue sizing and symbol slot timing for the e-link word path
`ifndef ELINK_MACROS_SVH
`define ELINK_MACROS_SVH

// Entries per word queue, power of two
`define ELINK_FIFO_DEPTH 8

// Lane cycles per 10-bit symbol at 2 bits per cycle
`define ELINK_SLOT_CYCLES 5

`endif

/* logic/linkPkg.sv */
// Line-code package: symbol and lane types, K28 codes, 5b6b/3b4b tables
// and the per-block encode helpers shared by encoder and decoder
`default_nettype none

package linkPkg;

  typedef logic [9:0] symbol10T; // abcdei fghj, bit 9 = a, sent first
  typedef logic [1:0] laneT;     // Bit 1 leaves first

  // K28.x at negative disparity; positive form is the complement
  localparam symbol10T commaNeg = 10'b0011111010; // K28.5
  localparam symbol10T commaPos = 10'b1100000101;
  localparam symbol10T k281Neg  = 10'b0011111001; // Start of packet
  localparam symbol10T k282Neg  = 10'b0011110101; // End of packet

  // 5b6b, RD- column, indexed by EDCBA
  localparam logic [5:0] code6Tab [32] = '{
    6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
    6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
    6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
    6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011
  };

  // 3b4b, RD- column, indexed by HGF; entry 7 is the primary P7
  localparam logic [3:0] code4Tab [8] = '{
    4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110
  };
  localparam logic [3:0] altSeven = 4'b0111; // A7, avoids a run of five

  // 6-bit block for the current disparity rd (1 = positive)
  function automatic logic [5:0] enc6(input logic [4:0] x, input logic rd);
    logic [5:0] t;
    t = code6Tab[x];
    if (rd && ($countones(t) != 3 || x == 5'd7)) // D.7 flips though balanced
      t = ~t;
    return t;
  endfunction

  // 4-bit block for the disparity after the 6-bit block
  function automatic logic [3:0] enc4(input logic [2:0] y, input logic rd, input logic alt);
    logic [3:0] t;
    t = (alt && y == 3'd7) ? altSeven : code4Tab[y];
    if (rd && ($countones(t) != 2 || y == 3'd3)) // Same for x.3
      t = ~t;
    return t;
  endfunction

endpackage

`default_nettype wire

/* logic/wordPkg.sv */
// User word package: delimiter kind plus transmit and receive word structs
`default_nettype none

package wordPkg;

  // Non-data kinds travel as K28.1, K28.2 and K28.5
  typedef enum logic [1:0] {
    kindData = 2'd0,
    kindSop  = 2'd1,
    kindEop  = 2'd2,
    kindIdle = 2'd3
  } kindT;

  typedef struct packed {
    kindT       kind;
    logic [7:0] data; // Ignored unless kindData
  } txWordT;

  typedef struct packed {
    kindT       kind;
    logic [7:0] data;    // Zero for K-characters
    logic       codeErr; // Unknown group or disparity violation
  } rxWordT;

endpackage

`default_nettype wire

/* logic/syncFifo.sv */
// Synchronous FIFO with first-word-fall-through head and a typed payload
`timescale 1ns/1ps
`default_nettype none
`include "elink_macros.svh"

module syncFifo #(
  parameter type payloadT = logic [7:0]
) (
  input  logic    getDataTrig,
  input  logic    rstN,
  input  logic    wrEn,
  input  payloadT din,
  input  logic    rdEn,
  output payloadT dout,
  output logic    full,
  output logic    empty
);
  localparam int depth = `ELINK_FIFO_DEPTH;
  localparam int ptrW  = $clog2(depth);

  payloadT         mem [depth];
  logic [ptrW-1:0] wrPtr;
  logic [ptrW-1:0] rdPtr;
  logic [ptrW:0]   count; // Occupancy, 0 to depth
  logic            doWr;
  logic            doRd;

  assign doWr  = wrEn && !full;  // Write dropped when full
  assign doRd  = rdEn && !empty;
  assign full  = count == (ptrW + 1)'(depth);
  assign empty = count == '0;
  assign dout  = mem[rdPtr];     // Head visible without a read

  always_ff @(posedge getDataTrig)
  begin
    if (doWr)
      mem[wrPtr] <= din;
  end

  always_ff @(posedge getDataTrig or negedge rstN)
  begin
    if (!rstN)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (doWr)
        wrPtr <= wrPtr + 1'b1; // Wraps at power-of-two depth
      if (doRd)
        rdPtr <= rdPtr + 1'b1;
      case ({doWr, doRd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/txEncoder.sv */
// 8b10b encoder with running disparity and K28 delimiters,
// loaded once per slot into a 10-to-2 shift serializer
`timescale 1ns/1ps
`default_nettype none

module txEncoder (
  input  logic            getDataTrig,
  input  logic            rstN,
  input  wordPkg::txWordT word,
  input  logic            slotStart,
  input  logic            useIdle,
  output linkPkg::laneT   edataOut
);
  import wordPkg::*;
  import linkPkg::*;

  kindT       kind;
  logic [4:0] x;       // EDCBA
  logic [2:0] y;       // HGF
  logic       rdCur;   // Running disparity, 1 = positive
  logic       rd6;     // After the 6-bit block
  logic       rdData;  // After a data symbol
  logic       useAlt;
  logic [5:0] code6;
  logic [3:0] code4;
  symbol10T   kNeg;
  symbol10T   symNext;
  symbol10T   shifter;

  always_comb
  begin
    kind  = useIdle ? kindIdle : word.kind;
    x     = word.data[4:0];
    y     = word.data[7:5];
    code6 = enc6(x, rdCur);
    rd6   = ($countones(code6) == 3) ? rdCur : ~rdCur;
    // A7 where P7 would join a run of five
    useAlt = (y == 3'd7) &&
             (rd6 ? (x == 5'd11 || x == 5'd13 || x == 5'd14)
                  : (x == 5'd17 || x == 5'd18 || x == 5'd20));
    code4  = enc4(y, rd6, useAlt);
    rdData = ($countones(code4) == 2) ? rd6 : ~rd6;
    case (kind)
      kindSop: kNeg = k281Neg;
      kindEop: kNeg = k282Neg;
      default: kNeg = commaNeg; // Idle
    endcase
    if (kind == kindData)
      symNext = {code6, code4};
    else
      symNext = rdCur ? ~kNeg : kNeg; // Every K28 used flips disparity
  end

  always_ff @(posedge getDataTrig or negedge rstN)
  begin
    if (!rstN)
    begin
      rdCur   <= 1'b0; // Start negative
      shifter <= '0;
    end
    else if (slotStart)
    begin
      shifter <= symNext;
      rdCur   <= (kind == kindData) ? rdData : ~rdCur;
    end
    else
      shifter <= {shifter[7:0], 2'b00}; // Two bits per cycle
  end

  assign edataOut = shifter[9:8]; // a, b first

endmodule

`default_nettype wire

/* logic/rxAligner.sv */
// Lane deserializer window with comma match at every 2-bit phase
`timescale 1ns/1ps
`default_nettype none

module rxAligner (
  input  logic              getDataTrig,
  input  logic              rstN,
  input  linkPkg::laneT     edataIn,
  output linkPkg::symbol10T window,
  output logic              commaHit
);
  import linkPkg::*;

  // Oldest bits at the top, matching symbol bit order
  always_ff @(posedge getDataTrig or negedge rstN)
  begin
    if (!rstN)
      window <= '0;
    else
      window <= {window[7:0], edataIn};
  end

  // Either polarity; 0011111/1100000 only shows up aligned
  assign commaHit = (window == commaNeg) || (window == commaPos);

endmodule

`default_nettype wire

/* logic/rxDecoder.sv */
// 8b10b decoder: reverse table search, K28 delimiters, running disparity
// tracking with code and disparity error flag
`timescale 1ns/1ps
`default_nettype none

module rxDecoder (
  input  logic              getDataTrig,
  input  logic              rstN,
  input  linkPkg::symbol10T window,
  input  logic              symStrobe,
  output wordPkg::rxWordT   decWord,
  output logic              decValid
);
  import linkPkg::*;
  import wordPkg::*;

  logic       rdCur;  // Expected disparity, 1 = positive
  logic       rd6;    // Carried by received 6-bit block
  logic       rdNext;
  logic [5:0] w6;
  logic [3:0] w4;
  logic       hit6, hit4;
  logic       bad6, bad4; // Group valid only at the other disparity
  logic       kBad;
  logic [4:0] x;
  logic [2:0] y;
  logic [2:0] yCand;
  kindT       kind;
  rxWordT     decNext;

  assign w6 = window[9:4];
  assign w4 = window[3:0];

  // Disparity follows what arrived, so one error does not cascade
  assign rd6    = ($countones(w6) == 3) ? rdCur : ($countones(w6) > 3);
  assign rdNext = ($countones(w4) == 2) ? rd6 : ($countones(w4) > 2);

  always_comb
  begin
    hit6  = 1'b0;
    bad6  = 1'b0;
    hit4  = 1'b0;
    bad4  = 1'b0;
    x     = '0;
    y     = '0;
    yCand = '0;
    // Groups are unique across both columns, so at most one match
    for (int i = 0; i < 32; i++)
    begin
      if (w6 == enc6(5'(i), rdCur))
      begin
        hit6 = 1'b1;
        x    = 5'(i);
      end
      else if (w6 == enc6(5'(i), ~rdCur))
      begin
        hit6 = 1'b1;
        bad6 = 1'b1;
        x    = 5'(i);
      end
    end
    for (int j = 0; j < 9; j++)
    begin
      yCand = (j == 8) ? 3'd7 : 3'(j); // Slot 8 is A7
      if (w4 == enc4(yCand, rd6, j == 8))
      begin
        hit4 = 1'b1;
        y    = yCand;
      end
      else if (w4 == enc4(yCand, ~rd6, j == 8))
      begin
        hit4 = 1'b1;
        bad4 = 1'b1;
        y    = yCand;
      end
    end
    kind = kindData;
    kBad = 1'b0;
    if (window == commaNeg || window == commaPos)
      kind = kindIdle; // Either polarity, resyncs disparity
    else if (window == k281Neg || window == ~k281Neg)
    begin
      kind = kindSop;
      kBad = window != (rdCur ? ~k281Neg : k281Neg);
    end
    else if (window == k282Neg || window == ~k282Neg)
    begin
      kind = kindEop;
      kBad = window != (rdCur ? ~k282Neg : k282Neg);
    end
    decNext.kind    = kind;
    decNext.data    = (kind == kindData) ? {y, x} : 8'h00;
    decNext.codeErr = (kind == kindData) ? (!hit6 || !hit4 || bad6 || bad4) : kBad;
  end

  always_ff @(posedge getDataTrig or negedge rstN)
  begin
    if (!rstN)
    begin
      rdCur    <= 1'b0;
      decValid <= 1'b0;
    end
    else
    begin
      decValid <= symStrobe; // Word ready the cycle after the strobe
      if (symStrobe)
        rdCur <= rdNext;
    end
  end

  always_ff @(posedge getDataTrig)
  begin
    if (symStrobe)
      decWord <= decNext;
  end

endmodule

`default_nettype wire

/* logic/elinkCtrl.sv */
// Link control: transmit slot counter and pop, receive hunt/lock FSM
// with phase counter and error run, receive push and overflow flag
`timescale 1ns/1ps
`default_nettype none
`include "elink_macros.svh"

module elinkCtrl (
  input  logic            getDataTrig,
  input  logic            rstN,
  input  logic            txEmpty,
  output logic            txPop,
  output logic            slotStart,
  input  logic            commaHit,
  input  logic            decValid,
  input  wordPkg::rxWordT decWord,
  input  logic            rxFullIn,
  output logic            rxPush,
  output logic            symStrobe,
  output logic            locked,
  output logic            rxOverflow
);
  import wordPkg::*;

  localparam int slotW = $clog2(`ELINK_SLOT_CYCLES);
  localparam logic [slotW-1:0] slotLast = slotW'(`ELINK_SLOT_CYCLES - 1);

  typedef enum logic {
    stHunt,
    stLocked
  } lockStateT;

  lockStateT        state;
  logic [slotW-1:0] slotCnt;  // Transmit slot position
  logic [slotW-1:0] phaseCnt; // Receive symbol phase
  logic [1:0]       errRun;   // Consecutive bad symbols
  logic             wantPush; // Decoded word worth keeping
  logic             decErr;

  assign slotStart = slotCnt == '0;
  assign txPop     = slotStart && !txEmpty;

  assign wantPush = decValid && decWord.kind != kindIdle;
  assign rxPush   = wantPush && !rxFullIn;
  assign decErr   = decValid && decWord.codeErr;

  // Hunting: decode the comma that triggers lock
  assign symStrobe = (state == stHunt) ? commaHit : (phaseCnt == slotLast);
  assign locked    = state == stLocked;

  always_ff @(posedge getDataTrig or negedge rstN)
  begin
    if (!rstN)
      slotCnt <= '0;
    else
      slotCnt <= (slotCnt == slotLast) ? '0 : slotCnt + 1'b1;
  end

  always_ff @(posedge getDataTrig or negedge rstN)
  begin
    if (!rstN)
    begin
      state    <= stHunt;
      phaseCnt <= '0;
      errRun   <= '0;
    end
    else
    begin
      case (state)
        stHunt:
        begin
          if (commaHit)
          begin
            state    <= stLocked;
            phaseCnt <= '0; // Next symbol ends five cycles on
            errRun   <= '0;
          end
        end
        default:
        begin
          phaseCnt <= (phaseCnt == slotLast) ? '0 : phaseCnt + 1'b1;
          if (decErr)
          begin
            if (errRun == 2'd2)
            begin
              state  <= stHunt; // Third bad symbol in a row
              errRun <= '0;
            end
            else
              errRun <= errRun + 1'b1;
          end
          else if (decValid)
            errRun <= '0;
        end
      endcase
    end
  end

  // Sticky drop flag
  always_ff @(posedge getDataTrig or negedge rstN)
  begin
    if (!rstN)
      rxOverflow <= 1'b0;
    else if (wantPush && rxFullIn)
      rxOverflow <= 1'b1;
  end

endmodule

`default_nettype wire

/* logic/elinkLoop.sv */
// E-link word path top: transmit and receive queues, slot and lock control,
// 8b10b encoder with serializer, comma aligner and decoder
`timescale 1ns/1ps
`default_nettype none

module elinkLoop (
  input  logic            getDataTrig,
  input  logic            rstN,
  input  wordPkg::txWordT txWord,
  input  logic            txWrEn,
  output logic            txFull,
  output wordPkg::rxWordT rxWord,
  input  logic            rxRdEn,
  output logic            rxEmpty,
  output linkPkg::laneT   edataOut,
  input  linkPkg::laneT   edataIn,
  output logic            locked,
  output logic            rxOverflow
);
  import wordPkg::*;
  import linkPkg::*;

  txWordT   txHead;       // FWFT head of transmit queue
  logic     txEmpty;
  logic     txPop;
  logic     slotStart;
  symbol10T window;       // Last 10 lane bits
  logic     commaHit;
  logic     symStrobe;
  rxWordT   decWord;
  logic     decValid;
  logic     rxPush;
  logic     rxFullInt;

  syncFifo #(.payloadT(txWordT)) u_txFifo (
    .getDataTrig (getDataTrig),
    .rstN        (rstN),
    .wrEn        (txWrEn),
    .din         (txWord),
    .rdEn        (txPop),
    .dout        (txHead),
    .full        (txFull),
    .empty       (txEmpty)
  );

  elinkCtrl u_ctrl (
    .getDataTrig (getDataTrig),
    .rstN        (rstN),
    .txEmpty     (txEmpty),
    .txPop       (txPop),
    .slotStart   (slotStart),
    .commaHit    (commaHit),
    .decValid    (decValid),
    .decWord     (decWord),
    .rxFullIn    (rxFullInt),
    .rxPush      (rxPush),
    .symStrobe   (symStrobe),
    .locked      (locked),
    .rxOverflow  (rxOverflow)
  );

  // Empty queue at slot start means an idle comma goes out
  txEncoder u_txEncoder (
    .getDataTrig (getDataTrig),
    .rstN        (rstN),
    .word        (txHead),
    .slotStart   (slotStart),
    .useIdle     (txEmpty),
    .edataOut    (edataOut)
  );

  rxAligner u_rxAligner (
    .getDataTrig (getDataTrig),
    .rstN        (rstN),
    .edataIn     (edataIn),
    .window      (window),
    .commaHit    (commaHit)
  );

  rxDecoder u_rxDecoder (
    .getDataTrig (getDataTrig),
    .rstN        (rstN),
    .window      (window),
    .symStrobe   (symStrobe),
    .decWord     (decWord),
    .decValid    (decValid)
  );

  syncFifo #(.payloadT(rxWordT)) u_rxFifo (
    .getDataTrig (getDataTrig),
    .rstN        (rstN),
    .wrEn        (rxPush),
    .din         (decWord),
    .rdEn        (rxRdEn),
    .dout        (rxWord),
    .full        (rxFullInt),
    .empty       (rxEmpty)
  );

endmodule

`default_nettype wire

/* tb/tbElinkLoop.sv */
// E-link loopback testbench with clock, reset, word stimulus, delay line,
// reference model, read-side compare and watchdog
`timescale 1ns/1ps
`default_nettype none
`include "elink_macros.svh"

module tbElinkLoop;
  import wordPkg::*;
  import linkPkg::*;

  localparam int depth       = `ELINK_FIFO_DEPTH;
  localparam int slotCycles  = `ELINK_SLOT_CYCLES;
  localparam int pktData     = 16;             // Data words per packet
  localparam int rndPerPhase = 60;             // Random words per delay
  localparam int totalWords  = (2 + 2 * pktData) + 3 * depth + 5 * rndPerPhase;
  localparam int watchdogCycles = slotCycles * totalWords * 4 + 2000;

  logic    getDataTrig;
  logic    rstN;
  txWordT  txWord;
  logic    txWrEn;
  logic    txFull;
  rxWordT  rxWord;
  logic    rxRdEn = 1'b0;
  logic    rxEmpty;
  laneT    edataOut;
  laneT    edataIn = '0;
  logic    locked;
  logic    rxOverflow;

  laneT    dly [4] = '{default: '0}; // Loopback delay taps
  int      lineDelay = 0;            // Lane steps from 0 to 4
  integer  seed;
  string   testName = "init";
  rxWordT  expQ [$];                 // Expected words in order
  logic    readOn = 1'b1;
  int      readLimit = 32'h7fffffff;
  int      readCount = 0;
  logic    sawTxFull = 1'b0;

  elinkLoop u_elinkLoop (
    .getDataTrig (getDataTrig),
    .rstN        (rstN),
    .txWord      (txWord),
    .txWrEn      (txWrEn),
    .txFull      (txFull),
    .rxWord      (rxWord),
    .rxRdEn      (rxRdEn),
    .rxEmpty     (rxEmpty),
    .edataOut    (edataOut),
    .edataIn     (edataIn),
    .locked      (locked),
    .rxOverflow  (rxOverflow)
  );

  initial
  begin
    getDataTrig = 1'b0;
    forever #10 getDataTrig = ~getDataTrig; // 20 ns period
  end

  // Print the reason and stop the run
  task automatic abortRun(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1, "run aborted on first error");
  endtask

  // Expected receive word keeps the kind and clears codeErr
  function automatic rxWordT refWord(input txWordT w);
    rxWordT e;
    e.kind    = w.kind;
    e.data    = (w.kind == kindData) ? w.data : 8'h00; // Byte only for data
    e.codeErr = 1'b0;
    return e;
  endfunction

  function automatic txWordT makeWord(input kindT k);
    txWordT w;
    w.kind = k;
    w.data = 8'($random(seed)); // Byte random even for K kinds
    return w;
  endfunction

  // Mostly data with some delimiters and idles
  function automatic txWordT randomWord();
    logic [3:0] pick;
    pick = 4'($random(seed));
    if (pick < 4'd10)
      return makeWord(kindData);
    else if (pick < 4'd12)
      return makeWord(kindSop);
    else if (pick < 4'd14)
      return makeWord(kindEop);
    return makeWord(kindIdle);
  endfunction

  // Loopback line samples edataOut while it is stable
  always @(negedge getDataTrig)
  begin
    edataIn = (lineDelay == 0) ? edataOut : dly[lineDelay - 1];
    for (int i = 3; i > 0; i--)
      dly[i] = dly[i - 1];
    dly[0] = edataOut;
  end

  // Reader and compare process
  always @(negedge getDataTrig)
  begin
    if (readOn && !rxEmpty && readCount < readLimit)
    begin
      rxRdEn = 1'b1;              // Pops on next rising edge
      checkWord(rxWord);
      readCount = readCount + 1;
    end
    else
      rxRdEn = 1'b0;
  end

  task automatic checkWord(input rxWordT got);
    rxWordT exp;
    assert (expQ.size() != 0)
    else
      abortRun($sformatf("Word %h showed up at rxWord in %s but none was due", got, testName));
    exp = expQ.pop_front();
    assert (got === exp)
    else
      abortRun($sformatf("Fail %s: expected %h, actual %h", testName, exp, got));
  endtask

  // Drive one word on a falling edge and hold off while txFull
  task automatic sendWord(input txWordT w);
    @(negedge getDataTrig);
    txWrEn = 1'b0;
    while (txFull)
    begin
      sawTxFull = 1'b1;
      @(negedge getDataTrig);
    end
    txWord = w;
    txWrEn = 1'b1;
    if (w.kind != kindIdle)
      expQ.push_back(refWord(w)); // Idles never reach the reader
  endtask

  task automatic holdOff(input int n);
    repeat (n)
    begin
      @(negedge getDataTrig);
      txWrEn = 1'b0;
    end
  endtask

  task automatic applyReset(input int d);
    @(negedge getDataTrig);
    rstN      = 1'b0;
    txWrEn    = 1'b0;
    lineDelay = d;
    repeat (5) @(negedge getDataTrig); // Flushes the delay line too
    rstN = 1'b1;
  endtask

  // Status right after reset and the first slot on the lane
  task automatic checkResetState();
    logic [3:0] got;
    symbol10T   lane;
    @(negedge getDataTrig);
    got = {txFull, locked, rxOverflow, rxEmpty};
    assert (got == 4'b0001)
    else
      abortRun($sformatf("Fail %s: expected %b, actual %b", testName, 4'b0001, got));
    lane = '0;
    for (int i = 0; i < slotCycles; i++)
    begin
      if (i != 0)
        @(negedge getDataTrig);
      lane = {lane[7:0], edataOut};
    end
    assert (lane == 10'b0011111010) // K28.5 at negative disparity
    else
      abortRun($sformatf("Fail %s: expected %b, actual %b", testName,
                         10'b0011111010, lane));
  endtask

  task automatic waitLock();
    int n;
    n = 0;
    while (!locked && n < 20)
    begin
      @(negedge getDataTrig);
      n++;
    end
    assert (locked)
    else
      abortRun($sformatf("Link did not lock within 20 cycles at delay %0d", lineDelay));
  endtask

  // Wait for all expected words and look for strays over a few slots
  task automatic waitDrain();
    int n;
    int limit;
    limit = 10 * (expQ.size() + depth) + 100;
    n = 0;
    while (expQ.size() != 0 && n < limit)
    begin
      @(negedge getDataTrig);
      n++;
    end
    assert (expQ.size() == 0)
    else
      abortRun($sformatf("%0d words never reached rxWord in %s", expQ.size(), testName));
    repeat (3 * slotCycles) @(negedge getDataTrig);
    assert (rxEmpty && !rxOverflow)
    else
      abortRun($sformatf("Receive side not idle or overflowed after %s", testName));
  endtask

  initial
  begin
    repeat (watchdogCycles) @(posedge getDataTrig);
    abortRun($sformatf("Watchdog expired after %0d cycles", watchdogCycles));
  end

  initial
  begin
    int d;
    int k;
    int n;
    seed   = 32'h4beff649;
    rstN   = 1'b0;
    txWord = '0;
    txWrEn = 1'b0;

    // Reset values and lock at every loopback phase
    for (d = 0; d < 5; d++)
    begin
      testName = $sformatf("reset and lock, delay %0d", d);
      applyReset(d);
      checkResetState();
      waitLock();
    end

    // One packet with idle writes and gaps in between
    testName = "packet";
    applyReset(2);
    waitLock();
    sendWord(makeWord(kindSop));
    for (k = 0; k < pktData; k++)
    begin
      holdOff($random(seed) & 3);
      if (($random(seed) & 3) == 0)
        sendWord(makeWord(kindIdle));
      sendWord(makeWord(kindData));
    end
    sendWord(makeWord(kindEop));
    holdOff(1);
    waitDrain();

    // Flood with reading stopped
    testName = "overflow";
    @(posedge getDataTrig);
    readOn    = 1'b0;
    sawTxFull = 1'b0;
    applyReset(1);
    waitLock();
    for (k = 0; k < 3 * depth; k++)
      sendWord(makeWord(kindData)); // Back to back
    holdOff(1);
    assert (sawTxFull)
    else
      abortRun("txFull never rose while the transmit queue was flooded");
    n = 0;
    while (!rxOverflow && n < 3 * depth * slotCycles + 50)
    begin
      @(negedge getDataTrig);
      n++;
    end
    assert (rxOverflow)
    else
      abortRun("rxOverflow did not set once the receive queue was full");
    @(posedge getDataTrig);
    readCount = 0;
    readLimit = depth;                 // Only the queued prefix
    readOn    = 1'b1;
    n = 0;
    while (readCount < depth && n < 100)
    begin
      @(negedge getDataTrig);
      n++;
    end
    assert (readCount == depth)
    else
      abortRun($sformatf("Fail %s: expected %0d, actual %0d", testName, depth, readCount));
    @(posedge getDataTrig);
    readOn = 1'b0;
    expQ.delete();                     // Dropped and late words discarded
    readLimit = 32'h7fffffff;

    // Long random traffic across all loopback phases
    for (d = 0; d < 5; d++)
    begin
      testName = $sformatf("random traffic, delay %0d", d);
      applyReset(d);
      readOn = 1'b1;                   // Receive queue is empty after reset
      waitLock();
      for (k = 0; k < rndPerPhase; k++)
      begin
        holdOff($random(seed) & 3);
        sendWord(randomWord());
      end
      holdOff(1);
      waitDrain();
    end

    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

/* elinkLoop.f */
+incdir+logic
logic/linkPkg.sv
logic/wordPkg.sv
logic/syncFifo.sv
logic/txEncoder.sv
logic/rxAligner.sv
logic/rxDecoder.sv
logic/elinkCtrl.sv
logic/elinkLoop.sv
tb/tbElinkLoop.sv

/* runSim.sh */
#!/bin/sh
# Builds the e-link loopback testbench with Verilator, runs it, checks the log
cd "$(dirname "$0")" || exit 1
logFile=sim.log
rm -f "$logFile"

verilator --binary --timing --assert -Wno-fatal --top-module tbElinkLoop \
  -f elinkLoop.f -Mdir obj_dir -o simElink \
  || { echo "Verilator build error"; exit 1; }

./obj_dir/simElink > "$logFile" 2>&1
cat "$logFile"

grep -qx "test passed" "$logFile" && echo "Simulation PASS" \
  || { echo "Simulation FAIL, see $logFile"; exit 1; }
